/* rv_pkg.sv */
// shared widths, instruction types, opcode encodings and control structs for the rv32i core
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       xlen_t;     // data or address word
    typedef logic [31:0]           inst_t;     // raw instruction word
    typedef logic [REG_ADDR_W-1:0] reg_addr_t; // x0..x31

    // major opcodes handled by the core
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        SRC_RS1_RS2,  // register forms, branch compares
        SRC_RS1_IMM,  // immediate forms
        SRC_PC_IMM,   // auipc
        SRC_PC_FOUR,  // link address for jal/jalr
        SRC_ZERO_IMM  // lui
    } alu_src_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_ZERO,      // taken when alu result is zero
        BR_NONZERO    // taken when alu result is nonzero
    } branch_e;

    typedef struct packed {
        logic      reg_wen;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_sel_e  imm_sel;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        branch_e   branch;
        logic      jump;     // jal or jalr
        logic      jalr;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t rd;
        xlen_t     wdata;
    } retire_t;

endpackage

`default_nettype wire

/* pc_unit.sv */
// program counter register and next-pc selection, instantiated by core_top
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter rv_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire logic          zero,
    input  wire rv_pkg::xlen_t imm,
    input  wire rv_pkg::xlen_t rs1_data,
    output rv_pkg::xlen_t      pc
);

    logic          br_taken;
    rv_pkg::xlen_t jalr_sum;
    rv_pkg::xlen_t next_pc;

    always_comb begin
        case (ctrl.branch)
            rv_pkg::BR_ZERO:    br_taken = zero;
            rv_pkg::BR_NONZERO: br_taken = !zero;
            default:            br_taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0}; // lsb cleared per spec
        end else if (ctrl.jump || br_taken) begin
            next_pc = pc + imm;  // jal or taken branch
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* decoder.sv */
// instruction decoder producing the control struct for one rv32i word per cycle
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire rv_pkg::inst_t inst,
    output rv_pkg::ctrl_t      ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // shared funct3 map for OP and OP-IMM, alt picks sub/sra
    function automatic rv_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = inst[11:7];
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.imm_sel = rv_pkg::IMM_I;
        ctrl.alu_op  = rv_pkg::ALU_ADD;
        ctrl.alu_src = rv_pkg::SRC_RS1_RS2;
        ctrl.branch  = rv_pkg::BR_NONE;

        case (opcode)
            rv_pkg::OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_U;
                ctrl.alu_src = rv_pkg::SRC_ZERO_IMM;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_U;
                ctrl.alu_src = rv_pkg::SRC_PC_IMM;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm_sel = rv_pkg::IMM_J;
                ctrl.alu_src = rv_pkg::SRC_PC_FOUR; // link address
                ctrl.jump    = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_pkg::SRC_PC_FOUR;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.illegal = (funct3 != 3'b000);
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.imm_sel = rv_pkg::IMM_B;
                case (funct3)
                    3'b000: begin // beq
                        ctrl.alu_op = rv_pkg::ALU_SUB;
                        ctrl.branch = rv_pkg::BR_ZERO;
                    end
                    3'b001: begin // bne
                        ctrl.alu_op = rv_pkg::ALU_SUB;
                        ctrl.branch = rv_pkg::BR_NONZERO;
                    end
                    3'b100, 3'b101: begin // blt, bge
                        ctrl.alu_op = rv_pkg::ALU_SLT;
                        ctrl.branch = funct3[0] ? rv_pkg::BR_ZERO : rv_pkg::BR_NONZERO;
                    end
                    3'b110, 3'b111: begin // bltu, bgeu
                        ctrl.alu_op = rv_pkg::ALU_SLTU;
                        ctrl.branch = funct3[0] ? rv_pkg::BR_ZERO : rv_pkg::BR_NONZERO;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = rv_pkg::SRC_RS1_IMM;
                ctrl.alu_op  = f3_to_alu(funct3, funct7[5] && funct3 == 3'b101);
                // shift immediates only allow srai as the alternate encoding
                if (funct3 == 3'b001) begin
                    ctrl.illegal = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end
            end
            rv_pkg::OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = f3_to_alu(funct3, funct7[5]);
                ctrl.illegal = (funct7 != 7'b0000000) &&
                               !(funct7 == 7'b0100000 &&
                                 (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default: ctrl.illegal = 1'b1; // loads, stores, system, fence
        endcase

        if (ctrl.illegal) begin // behave as a plain pc + 4 step
            ctrl.reg_wen = 1'b0;
            ctrl.branch  = rv_pkg::BR_NONE;
            ctrl.jump    = 1'b0;
            ctrl.jalr    = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* imm_gen.sv */
// immediate generator for the five rv32i formats, driven by the decoder select
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire rv_pkg::inst_t    inst,
    input  wire rv_pkg::imm_sel_e imm_sel,
    output rv_pkg::xlen_t         imm
);

    logic sign;

    assign sign = inst[31]; // all formats sign off bit 31

    always_comb begin
        case (imm_sel)
            rv_pkg::IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            rv_pkg::IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            rv_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
// integer register file with two async reads and one clocked write, x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              wen,
    input  wire rv_pkg::reg_addr_t waddr,
    input  wire rv_pkg::xlen_t     wdata,
    input  wire rv_pkg::reg_addr_t raddr1,
    input  wire rv_pkg::reg_addr_t raddr2,
    output rv_pkg::xlen_t          rdata1,
    output rv_pkg::xlen_t          rdata2
);

    rv_pkg::xlen_t regs [1:rv_pkg::NUM_REGS-1]; // no storage for x0

    always_ff @(posedge clk) begin
        if (!reset && wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, a write shows up next cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* alu.sv */
// operand select and arithmetic unit, also used as the branch comparator
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_e  alu_op,
    input  wire rv_pkg::alu_src_e alu_src,
    input  wire rv_pkg::xlen_t    rs1_data,
    input  wire rv_pkg::xlen_t    rs2_data,
    input  wire rv_pkg::xlen_t    imm,
    input  wire rv_pkg::xlen_t    pc,
    output rv_pkg::xlen_t         res,
    output logic                  zero
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    logic [4:0]    shamt;
    logic          lt_s;
    logic          lt_u;

    always_comb begin
        case (alu_src)
            rv_pkg::SRC_RS1_IMM:  begin op_a = rs1_data; op_b = imm;   end
            rv_pkg::SRC_PC_IMM:   begin op_a = pc;       op_b = imm;   end
            rv_pkg::SRC_PC_FOUR:  begin op_a = pc;       op_b = 32'd4; end
            rv_pkg::SRC_ZERO_IMM: begin op_a = '0;       op_b = imm;   end
            default:              begin op_a = rs1_data; op_b = rs2_data; end
        endcase
    end

    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_SUB:  res = op_a - op_b;
            rv_pkg::ALU_SLL:  res = op_a << shamt;
            rv_pkg::ALU_SLT:  res = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: res = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_XOR:  res = op_a ^ op_b;
            rv_pkg::ALU_SRL:  res = op_a >> shamt;
            rv_pkg::ALU_SRA:  res = rv_pkg::xlen_t'($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   res = op_a | op_b;
            rv_pkg::ALU_AND:  res = op_a & op_b;
            default:          res = op_a + op_b; // add and address math
        endcase
    end

    assign zero = (res == '0);

endmodule

`default_nettype wire

/* core_top.sv */
// single-cycle rv32i core top, fetches by pc and reports each register write on retire
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter rv_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire rv_pkg::inst_t inst,
    output rv_pkg::xlen_t      pc,
    output rv_pkg::retire_t    retire,
    output logic               illegal
);

    rv_pkg::ctrl_t ctrl;
    rv_pkg::xlen_t imm;
    rv_pkg::xlen_t rs1_data;
    rv_pkg::xlen_t rs2_data;
    rv_pkg::xlen_t alu_res;
    logic          zero;
    logic          retire_wen;

    pc_unit #(
        .RESET_PC ( RESET_PC )
    ) u_pc_unit_0 (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .ctrl     ( ctrl     ),
        .zero     ( zero     ),
        .imm      ( imm      ),
        .rs1_data ( rs1_data ),
        .pc       ( pc       )
    );

    decoder u_decoder_0 (
        .inst ( inst ),
        .ctrl ( ctrl )
    );

    imm_gen u_imm_gen_0 (
        .inst    ( inst         ),
        .imm_sel ( ctrl.imm_sel ),
        .imm     ( imm          )
    );

    reg_file u_reg_file_0 (
        .clk    ( clk          ),
        .reset  ( reset        ),
        .wen    ( ctrl.reg_wen ),
        .waddr  ( ctrl.rd      ),
        .wdata  ( alu_res      ),
        .raddr1 ( ctrl.rs1     ),
        .raddr2 ( ctrl.rs2     ),
        .rdata1 ( rs1_data     ),
        .rdata2 ( rs2_data     )
    );

    alu u_alu_0 (
        .alu_op   ( ctrl.alu_op  ),
        .alu_src  ( ctrl.alu_src ),
        .rs1_data ( rs1_data     ),
        .rs2_data ( rs2_data     ),
        .imm      ( imm          ),
        .pc       ( pc           ),
        .res      ( alu_res      ),
        .zero     ( zero         )
    );

    // writes to x0 are not reported as retired writes
    assign retire_wen = ctrl.reg_wen && (ctrl.rd != '0) && !reset;
    assign retire     = '{wen: retire_wen, rd: ctrl.rd, wdata: alu_res};
    assign illegal    = ctrl.illegal && !reset;

endmodule

`default_nettype wire

/* core_top_chk.sv */
// concurrent assertions on reset, retire and pc stepping, bound into core_top for simulation
`timescale 1ns/1ps
`default_nettype none

module core_top_chk #(
    parameter rv_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input wire logic            clk,
    input wire logic            reset,
    input wire rv_pkg::xlen_t   pc,
    input wire rv_pkg::retire_t retire,
    input wire logic            illegal,
    input wire rv_pkg::ctrl_t   ctrl,
    input wire logic            zero
);

    logic br_taken;
    int   fail_count = 0; // failed assertion count

    assign br_taken = (ctrl.branch == rv_pkg::BR_ZERO && zero) ||
                      (ctrl.branch == rv_pkg::BR_NONZERO && !zero);

    pc_after_reset: assert property (@(posedge clk) reset |=> (pc == RESET_PC))
        else begin
            fail_count++;
            $error("pc is not the reset vector after a reset cycle");
        end

    no_write_on_illegal: assert property (@(posedge clk) !(illegal && retire.wen))
        else begin
            fail_count++;
            $error("illegal instruction reported a register write");
        end

    no_write_in_reset: assert property (@(posedge clk) reset |-> !retire.wen)
        else begin
            fail_count++;
            $error("register write reported while reset is high");
        end

    // sequential flow only, branches and jumps have their own targets
    pc_step_four: assert property (@(posedge clk) disable iff (reset)
        (!ctrl.jump && !br_taken) |=> (pc == $past(pc) + 32'd4))
        else begin
            fail_count++;
            $error("pc did not advance by 4 on sequential flow");
        end

endmodule

bind core_top core_top_chk #(
    .RESET_PC ( RESET_PC )
) u_core_top_chk (
    .clk     ( clk     ),
    .reset   ( reset   ),
    .pc      ( pc      ),
    .retire  ( retire  ),
    .illegal ( illegal ),
    .ctrl    ( ctrl    ),
    .zero    ( zero    )
);

`default_nettype wire

/* tb_core_top.sv */
// testbench for core_top, runs a hand-checked program table and compares pc and retire per row
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    localparam int CLK_PERIOD = 100;
    localparam rv_pkg::inst_t ECALL = 32'h0000_0073; // system opcode, not supported

    typedef struct packed {
        rv_pkg::inst_t     inst;
        rv_pkg::xlen_t     pc;      // pc the word is fetched from
        logic              wen;
        rv_pkg::reg_addr_t rd;
        rv_pkg::xlen_t     wdata;
        logic              illegal;
    } row_t;

    logic            clk;
    logic            reset;
    rv_pkg::inst_t   inst;
    rv_pkg::xlen_t   pc;
    rv_pkg::retire_t retire;
    logic            illegal;

    row_t prog[$];
    int   errors = 0;
    int   checks = 0;

    core_top dut_i (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .inst    ( inst    ),
        .pc      ( pc      ),
        .retire  ( retire  ),
        .illegal ( illegal )
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic rv_pkg::inst_t reg_op(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::inst_t imm_op(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::inst_t branch_op(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t upper_op(logic [6:0] opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::inst_t jal_op(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    task automatic add_row(input rv_pkg::inst_t word, input rv_pkg::xlen_t at_pc,
                           input logic wen, input int rd, input rv_pkg::xlen_t wdata,
                           input logic ill);
        row_t r;
        r.inst    = word;
        r.pc      = at_pc;
        r.wen     = wen && (rd != 0); // x0 writes are not retired
        r.rd      = rd[4:0];
        r.wdata   = wdata;
        r.illegal = ill;
        prog.push_back(r);
    endtask

    task automatic check_value(input string name, input int row,
                               input rv_pkg::xlen_t exp_val, input rv_pkg::xlen_t act_val);
        checks++;
        assert (act_val === exp_val) else begin
            errors++;
            $display("ERROR %s row %0d expected 0x%08h actual 0x%08h",
                     name, row, exp_val, act_val);
        end
    endtask

    task automatic build_program();
        // alu group, results feed later rows
        add_row(upper_op(rv_pkg::OPC_LUI, 1, 'h12345),     32'h8000_0000, 1, 1,  32'h1234_5000, 0);
        add_row(upper_op(rv_pkg::OPC_AUIPC, 2, 'h00001),   32'h8000_0004, 1, 2,  32'h8000_1004, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 0, 3, 0, -5),   32'h8000_0008, 1, 3,  32'hFFFF_FFFB, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 0, 4, 0, 7),    32'h8000_000C, 1, 4,  32'h0000_0007, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 2, 5, 3, -4),   32'h8000_0010, 1, 5,  32'h0000_0001, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 4, 6, 1, 'hFF), 32'h8000_0014, 1, 6,  32'h1234_50FF, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 1, 7, 4, 4),    32'h8000_0018, 1, 7,  32'h0000_0070, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 5, 8, 3, 28),   32'h8000_001C, 1, 8,  32'h0000_000F, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 5, 9, 3, 'h401), 32'h8000_0020, 1, 9, 32'hFFFF_FFFD, 0);
        add_row(reg_op('h00, 0, 10, 1, 4),  32'h8000_0024, 1, 10, 32'h1234_5007, 0);
        add_row(reg_op('h20, 0, 11, 4, 3),  32'h8000_0028, 1, 11, 32'h0000_000C, 0);
        add_row(reg_op('h00, 1, 12, 4, 4),  32'h8000_002C, 1, 12, 32'h0000_0380, 0);
        add_row(reg_op('h00, 2, 13, 3, 4),  32'h8000_0030, 1, 13, 32'h0000_0001, 0);
        add_row(reg_op('h00, 3, 14, 3, 4),  32'h8000_0034, 1, 14, 32'h0000_0000, 0);
        add_row(reg_op('h00, 4, 15, 1, 6),  32'h8000_0038, 1, 15, 32'h0000_00FF, 0);
        add_row(reg_op('h00, 5, 16, 3, 4),  32'h8000_003C, 1, 16, 32'h01FF_FFFF, 0);
        add_row(reg_op('h20, 5, 17, 3, 4),  32'h8000_0040, 1, 17, 32'hFFFF_FFFF, 0);
        add_row(reg_op('h00, 6, 18, 4, 7),  32'h8000_0044, 1, 18, 32'h0000_0077, 0);
        add_row(reg_op('h00, 7, 19, 6, 15), 32'h8000_0048, 1, 19, 32'h0000_00FF, 0);
        add_row(imm_op(rv_pkg::OPC_OP_IMM, 0, 0, 0, 5), 32'h8000_004C, 1, 0, 32'h5, 0);
        add_row(reg_op('h00, 0, 20, 0, 4),  32'h8000_0050, 1, 20, 32'h0000_0007, 0);
        // branches, x3 = -5 and x4 = x20 = 7
        add_row(branch_op(0, 4, 20, 8),  32'h8000_0054, 0, 0, '0, 0); // beq taken
        add_row(branch_op(0, 4, 3, 8),   32'h8000_005C, 0, 0, '0, 0);
        add_row(branch_op(1, 4, 3, 12),  32'h8000_0060, 0, 0, '0, 0); // bne taken
        add_row(branch_op(1, 4, 20, 8),  32'h8000_006C, 0, 0, '0, 0);
        add_row(branch_op(4, 3, 4, 16),  32'h8000_0070, 0, 0, '0, 0); // blt taken
        add_row(branch_op(4, 4, 3, 8),   32'h8000_0080, 0, 0, '0, 0);
        add_row(branch_op(5, 4, 3, -4),  32'h8000_0084, 0, 0, '0, 0); // bge back
        add_row(branch_op(5, 3, 4, 8),   32'h8000_0080, 0, 0, '0, 0);
        add_row(branch_op(6, 4, 3, 8),   32'h8000_0084, 0, 0, '0, 0); // bltu taken
        add_row(branch_op(6, 3, 4, 8),   32'h8000_008C, 0, 0, '0, 0);
        add_row(branch_op(7, 3, 4, 8),   32'h8000_0090, 0, 0, '0, 0); // bgeu taken
        add_row(branch_op(7, 4, 3, 8),   32'h8000_0098, 0, 0, '0, 0);
        // jumps, then illegal words, then reads of the link registers
        add_row(jal_op(21, 16),          32'h8000_009C, 1, 21, 32'h8000_00A0, 0);
        add_row(imm_op(rv_pkg::OPC_JALR, 0, 22, 21, 5), 32'h8000_00AC, 1, 22, 32'h8000_00B0, 0);
        add_row(ECALL,                   32'h8000_00A4, 0, 0, '0, 1);
        add_row(reg_op('h01, 0, 25, 4, 3), 32'h8000_00A8, 0, 0, '0, 1); // mul encoding
        add_row(reg_op('h00, 0, 23, 21, 0), 32'h8000_00AC, 1, 23, 32'h8000_00A0, 0);
        add_row(reg_op('h20, 0, 24, 22, 2), 32'h8000_00B0, 1, 24, 32'hFFFF_F0AC, 0);
    endtask

    initial begin
        #1;
        #((prog.size() + 10) * CLK_PERIOD);
        $display("watchdog expired before the program finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        inst  = imm_op(rv_pkg::OPC_OP_IMM, 0, 1, 0, 1);
        build_program();

        // an illegal word and a write during reset must both stay quiet
        for (int k = 0; k < 2; k++) begin
            @(negedge clk);
            inst = (k == 0) ? ECALL : imm_op(rv_pkg::OPC_OP_IMM, 0, 1, 0, 1);
            #(CLK_PERIOD/4);
            check_value("retire.wen", -1, 32'h0, 32'(retire.wen));
            check_value("illegal", -1, 32'h0, 32'(illegal));
        end
        @(negedge clk); // third reset edge has passed
        reset = 1'b0;

        foreach (prog[i]) begin
            inst = prog[i].inst;
            #(CLK_PERIOD/4); // outputs settled, well before the rising edge
            check_value("pc", i, prog[i].pc, pc);
            check_value("retire.wen", i, 32'(prog[i].wen), 32'(retire.wen));
            if (prog[i].wen) begin
                check_value("retire.rd", i, 32'(prog[i].rd), 32'(retire.rd));
                check_value("retire.wdata", i, prog[i].wdata, retire.wdata);
            end
            check_value("illegal", i, 32'(prog[i].illegal), 32'(illegal));
            @(negedge clk);
        end

        errors += dut_i.u_core_top_chk.fail_count; // bound assertions count as errors
        $display("rows %0d, checks %0d, assertion failures %0d, errors %0d", prog.size(),
                 checks, dut_i.u_core_top_chk.fail_count, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* core_top.f */
rv_pkg.sv
pc_unit.sv
decoder.sv
imm_gen.sv
reg_file.sv
alu.sv
core_top.sv
core_top_chk.sv
tb_core_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_core_top
FILELIST  := core_top.f
MDIR      := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(MDIR)
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, a crashed run has no pass line either
run: build
	-./$(MDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR) $(LOG)
